/* src/rv_pkg.sv */
package rv_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;

    typedef logic [xlen-1:0]       word_t;
    typedef logic [reg_addr_w-1:0] reg_idx_t;

    typedef enum logic [6:0] {
        op_alu_r  = 7'b0110011,
        op_alu_i  = 7'b0010011,
        op_load   = 7'b0000011,
        op_store  = 7'b0100011,
        op_branch = 7'b1100011,
        op_jal    = 7'b1101111,
        op_jalr   = 7'b1100111,
        op_lui    = 7'b0110111
    } opcode_t;

    // alu funct3
    localparam logic [2:0] f3_add = 3'b000;
    localparam logic [2:0] f3_sll = 3'b001;
    localparam logic [2:0] f3_xor = 3'b100;
    localparam logic [2:0] f3_srl = 3'b101;
    localparam logic [2:0] f3_or  = 3'b110;
    localparam logic [2:0] f3_and = 3'b111;

    // branch funct3, blt/bge compare unsigned
    localparam logic [2:0] f3_beq = 3'b000;
    localparam logic [2:0] f3_bne = 3'b001;
    localparam logic [2:0] f3_blt = 3'b100;
    localparam logic [2:0] f3_bge = 3'b101;

    localparam logic [2:0] f3_word = 3'b010; // lw / sw width
    localparam logic [2:0] f3_jalr = 3'b000;

    localparam logic [6:0] f7_sub = 7'b0100000;

    localparam word_t pc_step = 32'd4;

    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            reg_idx_t   rs2;
            reg_idx_t   rs1;
            logic [2:0] funct3;
            reg_idx_t   rd;
            logic [6:0] opcode;
        } r_fmt;
        struct packed {
            logic [11:0] imm_11_0;
            reg_idx_t    rs1;
            logic [2:0]  funct3;
            reg_idx_t    rd;
            logic [6:0]  opcode;
        } i_fmt;
        struct packed {
            logic [6:0] imm_11_5;
            reg_idx_t   rs2;
            reg_idx_t   rs1;
            logic [2:0] funct3;
            logic [4:0] imm_4_0;
            logic [6:0] opcode;
        } s_fmt;
        struct packed {
            logic       imm_12;
            logic [5:0] imm_10_5;
            reg_idx_t   rs2;
            reg_idx_t   rs1;
            logic [2:0] funct3;
            logic [3:0] imm_4_1;
            logic       imm_11;
            logic [6:0] opcode;
        } b_fmt;
        struct packed {
            logic       imm_20;
            logic [9:0] imm_10_1;
            logic       imm_11;
            logic [7:0] imm_19_12;
            reg_idx_t   rd;
            logic [6:0] opcode;
        } j_fmt;
        struct packed {
            logic [19:0] imm_31_12;
            reg_idx_t    rd;
            logic [6:0]  opcode;
        } u_fmt;
    } instr_u;

    typedef enum logic [1:0] {
        st_fetch = 2'd0,
        st_exec  = 2'd1,
        st_mem   = 2'd2
    } seq_state_t;

endpackage

/* src/rv_decoder.sv */
module rv_decoder
    import rv_pkg::*;
(
    input  instr_u     instr_i,
    output opcode_t    opcode_o,
    output logic [2:0] funct3_o,
    output logic       is_sub_o,
    output reg_idx_t   rs1_o,
    output reg_idx_t   rs2_o,
    output reg_idx_t   rd_o,
    output word_t      imm_o,
    output logic       use_imm_o,
    output logic       rd_write_o
);

    function automatic logic alu_f3_ok(input logic [2:0] f3);
        return f3 inside {f3_add, f3_xor, f3_or, f3_and, f3_sll, f3_srl};
    endfunction

    logic [6:0] raw_op;
    logic       legal;  // kept opcode and funct3 combination
    logic       writes; // format has a destination

    assign raw_op = instr_i.r_fmt.opcode; // opcode sits at the same place in every format

    always_comb begin
        legal     = 1'b0;
        writes    = 1'b0;
        funct3_o  = '0;
        is_sub_o  = 1'b0;
        rs1_o     = '0;
        rs2_o     = '0;
        rd_o      = '0;
        imm_o     = '0;
        use_imm_o = 1'b0;
        case (raw_op)
            op_alu_r: begin
                funct3_o = instr_i.r_fmt.funct3;
                rs1_o    = instr_i.r_fmt.rs1;
                rs2_o    = instr_i.r_fmt.rs2;
                rd_o     = instr_i.r_fmt.rd;
                is_sub_o = instr_i.r_fmt.funct7 == f7_sub;
                writes   = 1'b1;
                legal    = alu_f3_ok(funct3_o) &&
                           (instr_i.r_fmt.funct7 == '0 || (is_sub_o && funct3_o == f3_add));
            end
            op_alu_i, op_load, op_jalr: begin
                funct3_o  = instr_i.i_fmt.funct3;
                rs1_o     = instr_i.i_fmt.rs1;
                rd_o      = instr_i.i_fmt.rd;
                imm_o     = {{20{instr_i.i_fmt.imm_11_0[11]}}, instr_i.i_fmt.imm_11_0};
                use_imm_o = 1'b1;
                writes    = 1'b1;
                if (raw_op == op_alu_i) begin
                    // shift amounts must leave imm[11:5] clear, srai is not kept
                    legal = alu_f3_ok(funct3_o) &&
                            (!(funct3_o inside {f3_sll, f3_srl}) ||
                             instr_i.i_fmt.imm_11_0[11:5] == '0);
                end else if (raw_op == op_load) begin
                    legal = funct3_o == f3_word;
                end else begin
                    legal = funct3_o == f3_jalr;
                end
            end
            op_store: begin
                funct3_o  = instr_i.s_fmt.funct3;
                rs1_o     = instr_i.s_fmt.rs1;
                rs2_o     = instr_i.s_fmt.rs2;
                imm_o     = {{20{instr_i.s_fmt.imm_11_5[6]}}, instr_i.s_fmt.imm_11_5,
                             instr_i.s_fmt.imm_4_0};
                use_imm_o = 1'b1;
                legal     = funct3_o == f3_word;
            end
            op_branch: begin
                funct3_o = instr_i.b_fmt.funct3;
                rs1_o    = instr_i.b_fmt.rs1;
                rs2_o    = instr_i.b_fmt.rs2;
                imm_o    = {{19{instr_i.b_fmt.imm_12}}, instr_i.b_fmt.imm_12,
                            instr_i.b_fmt.imm_11, instr_i.b_fmt.imm_10_5,
                            instr_i.b_fmt.imm_4_1, 1'b0};
                legal    = funct3_o inside {f3_beq, f3_bne, f3_blt, f3_bge};
            end
            op_jal: begin
                rd_o   = instr_i.j_fmt.rd;
                imm_o  = {{11{instr_i.j_fmt.imm_20}}, instr_i.j_fmt.imm_20,
                          instr_i.j_fmt.imm_19_12, instr_i.j_fmt.imm_11,
                          instr_i.j_fmt.imm_10_1, 1'b0};
                writes = 1'b1;
                legal  = 1'b1;
            end
            op_lui: begin
                rd_o      = instr_i.u_fmt.rd;
                imm_o     = {instr_i.u_fmt.imm_31_12, 12'b0};
                use_imm_o = 1'b1;
                writes    = 1'b1;
                legal     = 1'b1;
            end
            default: legal = 1'b0;
        endcase
    end

    // anything unsupported decodes to opcode zero, which runs as a no-op
    assign opcode_o   = legal ? opcode_t'(raw_op) : opcode_t'(7'd0);
    assign rd_write_o = legal && writes && (rd_o != '0);

endmodule

/* src/rv_reg_file.sv */
module rv_reg_file
    import rv_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     we_i,
    input  reg_idx_t rd_i,
    input  reg_idx_t rs1_i,
    input  reg_idx_t rs2_i,
    input  word_t    wdata_i,
    output word_t    rs1_val_o,
    output word_t    rs2_val_o
);

    word_t regs [1:31]; // x0 is not stored

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && rd_i != '0) begin
            regs[rd_i] <= wdata_i;
        end
    end

    assign rs1_val_o = (rs1_i == '0) ? '0 : regs[rs1_i];
    assign rs2_val_o = (rs2_i == '0) ? '0 : regs[rs2_i];

endmodule

/* src/rv_alu.sv */
module rv_alu
    import rv_pkg::*;
(
    input  opcode_t    opcode_i,
    input  logic [2:0] funct3_i,
    input  logic       is_sub_i,
    input  logic       use_imm_i,
    input  word_t      rs1_val_i,
    input  word_t      rs2_val_i,
    input  word_t      imm_i,
    input  word_t      pc_i,
    output word_t      alu_result_o,
    output word_t      mem_adr_o,
    output logic       branch_taken_o
);

    word_t op_b;

    assign op_b      = use_imm_i ? imm_i : rs2_val_i;
    assign mem_adr_o = rs1_val_i + imm_i; // lw / sw effective address

    always_comb begin
        alu_result_o = '0;
        case (opcode_i)
            op_alu_r, op_alu_i: begin
                case (funct3_i)
                    f3_add:  alu_result_o = is_sub_i ? rs1_val_i - op_b : rs1_val_i + op_b;
                    f3_xor:  alu_result_o = rs1_val_i ^ op_b;
                    f3_or:   alu_result_o = rs1_val_i | op_b;
                    f3_and:  alu_result_o = rs1_val_i & op_b;
                    f3_sll:  alu_result_o = rs1_val_i << op_b[4:0];
                    f3_srl:  alu_result_o = rs1_val_i >> op_b[4:0];
                    default: alu_result_o = '0;
                endcase
            end
            op_lui:          alu_result_o = imm_i; // already shifted by the decoder
            op_jal, op_jalr: alu_result_o = pc_i + pc_step; // link
            default:         alu_result_o = '0;
        endcase
    end

    always_comb begin
        branch_taken_o = 1'b0;
        case (opcode_i)
            op_branch: begin
                case (funct3_i)
                    f3_beq:  branch_taken_o = rs1_val_i == rs2_val_i;
                    f3_bne:  branch_taken_o = rs1_val_i != rs2_val_i;
                    f3_blt:  branch_taken_o = rs1_val_i <  rs2_val_i; // unsigned
                    f3_bge:  branch_taken_o = rs1_val_i >= rs2_val_i;
                    default: branch_taken_o = 1'b0;
                endcase
            end
            op_jal, op_jalr: branch_taken_o = 1'b1;
            default:         branch_taken_o = 1'b0;
        endcase
    end

endmodule

/* src/rv_lsu.sv */
module rv_lsu
    import rv_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  logic  fetch_req_i,
    input  logic  data_req_i,
    input  logic  data_we_i,
    input  word_t pc_i,
    input  word_t mem_adr_i,
    input  word_t wdata_i,
    input  word_t bus_rdata_i,
    input  logic  bus_full_i,
    output logic  bus_req_o,
    output logic  bus_we_o,
    output word_t bus_adr_o,
    output word_t bus_wdata_o,
    output logic  xfer_done_o,
    output word_t rdata_o
);

    word_t rdata_q;

    // requester inputs stay put while the bus is full, so outputs hold too
    assign bus_req_o   = fetch_req_i | data_req_i;
    assign bus_we_o    = data_req_i & data_we_i;
    assign bus_adr_o   = data_req_i ? mem_adr_i : pc_i;
    assign bus_wdata_o = wdata_i;
    assign xfer_done_o = bus_req_o & ~bus_full_i;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rdata_q <= '0;
        end else if (xfer_done_o && !bus_we_o) begin
            rdata_q <= bus_rdata_i;
        end
    end

    // live word on the completing cycle, held copy afterwards
    assign rdata_o = (xfer_done_o && !bus_we_o) ? bus_rdata_i : rdata_q;

endmodule

/* src/rv_sequencer.sv */
module rv_sequencer
    import rv_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  opcode_t  opcode_i,
    input  logic     rd_write_i,
    input  reg_idx_t rd_i,
    input  word_t    imm_i,
    input  word_t    rs1_val_i,
    input  word_t    alu_result_i,
    input  logic     branch_taken_i,
    input  logic     xfer_done_i,
    input  word_t    rdata_i,
    output instr_u   instr_o,
    output word_t    pc_o,
    output logic     fetch_req_o,
    output logic     data_req_o,
    output logic     data_we_o,
    output logic     rf_we_o,
    output reg_idx_t rf_rd_o,
    output word_t    rf_wdata_o
);

    seq_state_t state_q;
    logic       started_q; // keeps the bus quiet in the first cycle out of reset
    word_t      pc_q;
    instr_u     ir_q;
    logic       is_mem;
    word_t      next_pc;

    assign is_mem      = (opcode_i == op_load) || (opcode_i == op_store);
    assign fetch_req_o = started_q && (state_q == st_fetch);
    assign data_req_o  = state_q == st_mem;
    assign data_we_o   = data_req_o && (opcode_i == op_store);
    assign instr_o     = ir_q;
    assign pc_o        = pc_q;

    always_comb begin
        next_pc = pc_q + pc_step;
        if (opcode_i == op_jalr) begin
            next_pc = (rs1_val_i + imm_i) & ~word_t'(1);
        end else if (branch_taken_i) begin
            next_pc = pc_q + imm_i; // taken branch or jal
        end
    end

    // writeback
    always_comb begin
        case (state_q)
            st_exec: rf_we_o = rd_write_i && !is_mem;
            st_mem:  rf_we_o = rd_write_i && xfer_done_i; // only lw has rd_write here
            default: rf_we_o = 1'b0;
        endcase
    end

    assign rf_rd_o    = rd_i;
    assign rf_wdata_o = (opcode_i == op_load) ? rdata_i : alu_result_i;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q   <= st_fetch;
            started_q <= 1'b0;
            pc_q      <= '0;
            ir_q      <= '0;
        end else begin
            started_q <= 1'b1;
            case (state_q)
                st_fetch: begin
                    if (xfer_done_i) begin
                        ir_q    <= rdata_i;
                        state_q <= st_exec;
                    end
                end
                st_exec: begin
                    if (is_mem) begin
                        state_q <= st_mem;
                    end else begin
                        pc_q    <= next_pc;
                        state_q <= st_fetch;
                    end
                end
                st_mem: begin
                    if (xfer_done_i) begin
                        pc_q    <= next_pc; // plain fall-through for lw / sw
                        state_q <= st_fetch;
                    end
                end
                default: state_q <= st_fetch;
            endcase
        end
    end

endmodule

/* src/rv_core.sv */
module rv_core
    import rv_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  word_t bus_rdata_i,
    input  logic  bus_full_i,
    output logic  bus_req_o,
    output logic  bus_we_o,
    output word_t bus_adr_o,
    output word_t bus_wdata_o
);

    instr_u     instr;
    opcode_t    opcode;
    logic [2:0] funct3;
    logic       is_sub;
    logic       use_imm;
    logic       rd_write;
    reg_idx_t   rs1;
    reg_idx_t   rs2;
    reg_idx_t   rd;
    word_t      imm;
    word_t      rs1_val;
    word_t      rs2_val;
    word_t      alu_result;
    word_t      mem_adr;
    logic       branch_taken;
    word_t      pc;
    logic       fetch_req;
    logic       data_req;
    logic       data_we;
    logic       xfer_done;
    word_t      rdata;
    logic       rf_we;
    reg_idx_t   rf_rd;
    word_t      rf_wdata;

    rv_sequencer u_seq (
        .clk            (clk),
        .rst            (rst),
        .opcode_i       (opcode),
        .rd_write_i     (rd_write),
        .rd_i           (rd),
        .imm_i          (imm),
        .rs1_val_i      (rs1_val),
        .alu_result_i   (alu_result),
        .branch_taken_i (branch_taken),
        .xfer_done_i    (xfer_done),
        .rdata_i        (rdata),
        .instr_o        (instr),
        .pc_o           (pc),
        .fetch_req_o    (fetch_req),
        .data_req_o     (data_req),
        .data_we_o      (data_we),
        .rf_we_o        (rf_we),
        .rf_rd_o        (rf_rd),
        .rf_wdata_o     (rf_wdata)
    );

    rv_decoder u_dec (
        .instr_i    (instr),
        .opcode_o   (opcode),
        .funct3_o   (funct3),
        .is_sub_o   (is_sub),
        .rs1_o      (rs1),
        .rs2_o      (rs2),
        .rd_o       (rd),
        .imm_o      (imm),
        .use_imm_o  (use_imm),
        .rd_write_o (rd_write)
    );

    rv_reg_file u_rf (
        .clk       (clk),
        .rst       (rst),
        .we_i      (rf_we),
        .rd_i      (rf_rd),
        .rs1_i     (rs1),
        .rs2_i     (rs2),
        .wdata_i   (rf_wdata),
        .rs1_val_o (rs1_val),
        .rs2_val_o (rs2_val)
    );

    rv_alu u_alu (
        .opcode_i       (opcode),
        .funct3_i       (funct3),
        .is_sub_i       (is_sub),
        .use_imm_i      (use_imm),
        .rs1_val_i      (rs1_val),
        .rs2_val_i      (rs2_val),
        .imm_i          (imm),
        .pc_i           (pc),
        .alu_result_o   (alu_result),
        .mem_adr_o      (mem_adr),
        .branch_taken_o (branch_taken)
    );

    rv_lsu u_lsu (
        .clk         (clk),
        .rst         (rst),
        .fetch_req_i (fetch_req),
        .data_req_i  (data_req),
        .data_we_i   (data_we),
        .pc_i        (pc),
        .mem_adr_i   (mem_adr),
        .wdata_i     (rs2_val),
        .bus_rdata_i (bus_rdata_i),
        .bus_full_i  (bus_full_i),
        .bus_req_o   (bus_req_o),
        .bus_we_o    (bus_we_o),
        .bus_adr_o   (bus_adr_o),
        .bus_wdata_o (bus_wdata_o),
        .xfer_done_o (xfer_done),
        .rdata_o     (rdata)
    );

endmodule

/* tests/tb_clk_gen.sv */
module tb_clk_gen #(
    parameter int period_ns = 8
) (
    output logic clk_o
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk_o = 1'b0;
        forever begin
            #(period_ns / 2.0) clk_o = ~clk_o; // 50% duty
        end
    end

endmodule

/* tests/rv_core_chk.sv */
module rv_core_chk
    import rv_pkg::*;
(
    input logic  clk,
    input logic  rst,
    input logic  bus_req_i,
    input logic  bus_we_i,
    input word_t bus_adr_i,
    input word_t bus_wdata_i,
    input word_t bus_rdata_i,
    input logic  bus_full_i
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam word_t data_base = 32'h100;
    localparam int    n_stores  = 22;

    // one store per result in order upward from data_base
    localparam word_t exp_data [n_stores] = '{
        32'h0000_0002, // add 5 + -3
        32'h0000_0008, // sub 5 - -3
        32'h1234_5005, // xor
        32'hFFFF_FFFD, // or
        32'h1234_5000, // and
        32'h468A_0000, // sll by 5
        32'h07FF_FFFF, // srl by 5
        32'hEDCB_AFFF, // xori -1
        32'h0000_07F5, // ori
        32'h0000_00F0, // andi
        32'h0000_0500, // slli 8
        32'h0001_2345, // srli 12
        32'h1234_5000, // lui
        32'h0000_0001, // beq taken
        32'h0000_0002, // beq not taken
        32'h0000_0001, // bne taken
        32'h0000_0002, // blt unsigned, not taken
        32'h0000_0001, // bge unsigned, taken
        32'h0000_00C8, // jal link
        32'h0000_00D4, // jalr link
        32'hFE07_01F8, // lw of the fill word at 0x1f8
        32'h0000_0000  // x0 after a write attempt
    };

    logic  failed = 1'b0; // sampled by tb_top
    logic  req_seen;
    logic  seq_pending;   // last fetch can only fall through
    word_t last_fetch;
    logic  rd_done;
    logic  fetch_done;

    function automatic logic store_known(input word_t adr);
        return adr >= data_base && adr < data_base + 4 * n_stores && adr[1:0] == 2'b00;
    endfunction

    function automatic word_t store_value(input word_t adr);
        if (!store_known(adr)) begin
            return '0;
        end
        return exp_data[(adr - data_base) >> 2];
    endfunction

    assign rd_done    = bus_req_i && !bus_we_i && !bus_full_i;
    assign fetch_done = rd_done && bus_adr_i < data_base; // program lives below data_base

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            req_seen    <= 1'b0;
            seq_pending <= 1'b0;
            last_fetch  <= '0;
        end else begin
            if (bus_req_i) begin
                req_seen <= 1'b1;
            end
            if (fetch_done) begin
                last_fetch  <= bus_adr_i;
                seq_pending <= !(bus_rdata_i[6:0] inside {op_branch, op_jal, op_jalr});
            end
        end
    end

    a_rst_quiet: assert property (@(posedge clk) rst |-> !bus_req_i && !bus_we_i)
        else begin
            failed = 1'b1;
            $error("bus request or write enable active during reset");
        end

    a_exit_quiet: assert property (@(posedge clk) $fell(rst) |-> !bus_req_i && !bus_we_i)
        else begin
            failed = 1'b1;
            $error("bus active in the first cycle after reset");
        end

    a_first_req: assert property (@(posedge clk) disable iff (rst)
        bus_req_i && !req_seen |-> !bus_we_i && bus_adr_i == '0)
        else begin
            failed = 1'b1;
            $error("first request is not a read at address zero");
        end

    a_hold: assert property (@(posedge clk) disable iff (rst)
        bus_req_i && bus_full_i |=> bus_req_i && $stable(bus_adr_i) && $stable(bus_we_i)
                                    && $stable(bus_wdata_i))
        else begin
            failed = 1'b1;
            $error("request dropped or changed while the bus was full");
        end

    a_we_in_req: assert property (@(posedge clk) bus_we_i |-> bus_req_i)
        else begin
            failed = 1'b1;
            $error("write enable high without a bus request");
        end

    a_store_adr: assert property (@(posedge clk) disable iff (rst)
        bus_req_i && bus_we_i && !bus_full_i |-> store_known(bus_adr_i))
        else begin
            failed = 1'b1;
            $error("store to unexpected address 0x%h", $sampled(bus_adr_i));
        end

    a_store_data: assert property (@(posedge clk) disable iff (rst)
        bus_req_i && bus_we_i && !bus_full_i |-> bus_wdata_i == store_value(bus_adr_i))
        else begin
            failed = 1'b1;
            $error("[ERROR] bus_wdata_o got 0x%h expected 0x%h (adr 0x%h)",
                   $sampled(bus_wdata_i), store_value($sampled(bus_adr_i)),
                   $sampled(bus_adr_i));
        end

    // next instruction word sits 4 bytes further on
    a_fall_through: assert property (@(posedge clk) disable iff (rst)
        fetch_done && seq_pending |-> bus_adr_i == last_fetch + 32'd4)
        else begin
            failed = 1'b1;
            $error("[ERROR] bus_adr_o got 0x%h expected 0x%h",
                   $sampled(bus_adr_i), $sampled(last_fetch) + 32'd4);
        end

endmodule

bind rv_core rv_core_chk chk0 (
    .clk         (clk),
    .rst         (rst),
    .bus_req_i   (bus_req_o),
    .bus_we_i    (bus_we_o),
    .bus_adr_i   (bus_adr_o),
    .bus_wdata_i (bus_wdata_o),
    .bus_rdata_i (bus_rdata_i),
    .bus_full_i  (bus_full_i)
);

/* tests/tb_top.sv */
module tb_top
    import rv_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int mem_words = 128; // 0x000 .. 0x1fc
    localparam int n_stores  = 22;

    logic  clk;
    logic  rst;
    word_t bus_rdata_i;
    logic  bus_full_i;
    logic  bus_req_o;
    logic  bus_we_o;
    word_t bus_adr_o;
    word_t bus_wdata_o;

    word_t mem [mem_words];
    int    n_instr;
    int    stores_seen;
    int    cycles;
    int    limit;

    tb_clk_gen #(.period_ns(8)) u_clk (.clk_o(clk));

    rv_core dut0 (
        .clk         (clk),
        .rst         (rst),
        .bus_rdata_i (bus_rdata_i),
        .bus_full_i  (bus_full_i),
        .bus_req_o   (bus_req_o),
        .bus_we_o    (bus_we_o),
        .bus_adr_o   (bus_adr_o),
        .bus_wdata_o (bus_wdata_o)
    );

    assign bus_rdata_i = mem[bus_adr_o[8:2]]; // read data in the same cycle

    function automatic word_t alu_reg(input logic [2:0] f3, input logic [6:0] f7,
                                      input int rd, input int rs1, input int rs2);
        return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], op_alu_r};
    endfunction

    function automatic word_t imm_form(input opcode_t op, input logic [2:0] f3,
                                       input int rd, input int rs1, input int imm);
        return {imm[11:0], rs1[4:0], f3, rd[4:0], op};
    endfunction

    function automatic word_t store_word(input int rs2, input int rs1, input int off);
        return {off[11:5], rs2[4:0], rs1[4:0], f3_word, off[4:0], op_store};
    endfunction

    function automatic word_t branch_if(input logic [2:0] f3, input int rs1, input int rs2,
                                        input int off);
        return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3, off[4:1], off[11], op_branch};
    endfunction

    function automatic word_t jump_link(input int rd, input int off);
        return {off[20], off[10:1], off[11], off[19:12], rd[4:0], op_jal};
    endfunction

    function automatic word_t upper_imm(input int rd, input int imm);
        return {imm[19:0], rd[4:0], op_lui};
    endfunction

    task automatic emit(input word_t w);
        mem[n_instr] <= w;
        n_instr++;
    endtask

    // x17 ends as 1 when taken, 2 when it falls through
    task automatic probe_branch(input logic [2:0] f3, input int rs1, input int rs2,
                                input int off);
        emit(imm_form(op_alu_i, f3_add, 17, 0, 1));
        emit(branch_if(f3, rs1, rs2, 8));
        emit(imm_form(op_alu_i, f3_add, 17, 0, 2));
        emit(store_word(17, 10, off));
    endtask

    task automatic load_program();
        emit(imm_form(op_alu_i, f3_add, 1, 0, 5));      // x1 = 5
        emit(imm_form(op_alu_i, f3_add, 2, 0, -3));     // x2 = -3
        emit(upper_imm(3, 'h12345));                    // x3 = 0x12345000
        emit(imm_form(op_alu_i, f3_add, 10, 0, 'h100)); // store base
        emit(alu_reg(f3_add, 7'd0, 4, 1, 2));
        emit(store_word(4, 10, 0));
        emit(alu_reg(f3_add, f7_sub, 5, 1, 2));
        emit(store_word(5, 10, 4));
        emit(alu_reg(f3_xor, 7'd0, 6, 3, 1));
        emit(store_word(6, 10, 8));
        emit(alu_reg(f3_or, 7'd0, 7, 3, 2));
        emit(store_word(7, 10, 12));
        emit(alu_reg(f3_and, 7'd0, 8, 3, 2));
        emit(store_word(8, 10, 16));
        emit(alu_reg(f3_sll, 7'd0, 9, 3, 1));
        emit(store_word(9, 10, 20));
        emit(alu_reg(f3_srl, 7'd0, 11, 2, 1));
        emit(store_word(11, 10, 24));
        emit(imm_form(op_alu_i, f3_xor, 12, 3, -1));
        emit(store_word(12, 10, 28));
        emit(imm_form(op_alu_i, f3_or, 13, 1, 'h7f0));
        emit(store_word(13, 10, 32));
        emit(imm_form(op_alu_i, f3_and, 14, 2, 'hf0));
        emit(store_word(14, 10, 36));
        emit(imm_form(op_alu_i, f3_sll, 15, 1, 8));
        emit(store_word(15, 10, 40));
        emit(imm_form(op_alu_i, f3_srl, 16, 3, 12));
        emit(store_word(16, 10, 44));
        emit(store_word(3, 10, 48));                    // lui result
        probe_branch(f3_beq, 1, 1, 52);
        probe_branch(f3_beq, 1, 2, 56);
        probe_branch(f3_bne, 1, 2, 60);
        probe_branch(f3_blt, 2, 1, 64);                 // unsigned, so not taken
        probe_branch(f3_bge, 2, 1, 68);
        emit(jump_link(18, 8));                         // link 0xc8
        emit(imm_form(op_alu_i, f3_add, 18, 0, 'h3ff)); // skipped
        emit(store_word(18, 10, 72));
        emit(imm_form(op_jalr, f3_jalr, 19, 18, 17));   // odd target, lands at 0xd8
        emit(imm_form(op_alu_i, f3_add, 19, 0, 'h3ff)); // skipped
        emit(store_word(19, 10, 76));
        emit(imm_form(op_load, f3_word, 20, 10, 248));  // fill word at 0x1f8
        emit(store_word(20, 10, 80));
        emit(imm_form(op_alu_i, f3_add, 0, 1, 7));      // write to x0
        emit(store_word(0, 10, 84));
        emit(jump_link(0, 0));                          // park here
    endtask

    // stall source, about one cycle in three
    initial begin
        bus_full_i <= 1'b0;
        void'($urandom(32'h6043_2511));
        forever begin
            @(posedge clk);
            bus_full_i <= ($urandom % 3) == 0;
        end
    end

    always @(posedge clk) begin
        if (rst) begin
            stores_seen <= 0;
            cycles      <= 0;
        end else begin
            cycles <= cycles + 1;
            if (bus_req_o && bus_we_o && !bus_full_i) begin
                stores_seen         <= stores_seen + 1;
                mem[bus_adr_o[8:2]] <= bus_wdata_o;
            end
        end
    end

    initial begin
        word_t adr;
        rst     <= 1'b1;
        n_instr = 0;
        for (int a = 0; a < mem_words; a++) begin
            adr    = a * 4;
            mem[a] <= {~adr[15:0], adr[15:0]};
        end
        load_program();
        limit = 40 * n_instr * 3;
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        while (stores_seen < n_stores && !dut0.chk0.failed && cycles < limit) begin
            @(posedge clk);
        end
        if (stores_seen == n_stores && !dut0.chk0.failed) begin
            $display("Verification passed");
            $finish;
        end else begin
            $display("Verification failed");
            if (cycles >= limit) begin
                $fatal(1, "timed out after %0d cycles with %0d of %0d stores seen",
                       cycles, stores_seen, n_stores);
            end else begin
                $fatal(1, "a checker assertion failed");
            end
        end
    end

endmodule

/* tb.f */
src/rv_pkg.sv
src/rv_decoder.sv
src/rv_reg_file.sv
src/rv_alu.sv
src/rv_lsu.sv
src/rv_sequencer.sv
src/rv_core.sv
tests/tb_clk_gen.sv
tests/rv_core_chk.sv
tests/tb_top.sv

/* Bender.yml */
package:
  name: rv_core

sources:
  - src/rv_pkg.sv
  - src/rv_decoder.sv
  - src/rv_reg_file.sv
  - src/rv_alu.sv
  - src/rv_lsu.sv
  - src/rv_sequencer.sv
  - src/rv_core.sv
  - target: test
    files:
      - tests/tb_clk_gen.sv
      - tests/rv_core_chk.sv
      - tests/tb_top.sv
